//--- Makefile
SIM      = verilator
TOP      = nw_tb
FILELIST = list.f
OBJ_DIR  = obj_dir
FLAGS    = --binary --timing --assert --top-module $(TOP) -Mdir $(OBJ_DIR)

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- hw/dir_store.sv
`timescale 1ns/1ps
`default_nettype none

module dir_store
    import nw_pkg::*;
(
    input  logic                          clk,
    input  logic [SEQ_LEN-1:0]            wr_en,
    input  logic [SEQ_LEN-1:0][IDX_W-1:0] wr_row,
    input  logic [SEQ_LEN-1:0][DIR_W-1:0] wr_dir,
    input  logic [IDX_W-1:0]              rd_row,
    input  logic [IDX_W-1:0]              rd_col,
    output logic [DIR_W-1:0]              rd_dir
);

    // Row and column 0 are boundary cells and stay unused
    logic [DIR_W-1:0] mem [0:SEQ_LEN][0:SEQ_LEN];

    // One write port per column
    always_ff @(posedge clk) begin
        for (int c = 0; c < SEQ_LEN; c++) begin
            if (wr_en[c]) begin
                mem[wr_row[c]][IDX_W'(c + 1)] <= wr_dir[c];
            end
        end
    end

    assign rd_dir = mem[rd_row][rd_col];  // Combinational read

endmodule

`default_nettype wire

//--- hw/nw_array.sv
`timescale 1ns/1ps
`default_nettype none

module nw_array
    import nw_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           start,
    input  logic [SEQ_LEN*BASE_W-1:0]      ref_seq,
    input  logic [SEQ_LEN*BASE_W-1:0]      qry_seq,
    input  logic                           done,
    output logic                           busy,
    output logic [SEQ_LEN-1:0]             wr_en,
    output logic [SEQ_LEN-1:0][IDX_W-1:0]  wr_row,
    output logic [SEQ_LEN-1:0][DIR_W-1:0]  wr_dir,
    output logic signed [SCORE_W-1:0]      final_score,
    output logic                           fill_done
);

    logic                          busy_q;
    logic                          accept;
    logic                          feeding;
    logic [IDX_W-1:0]              feed_row;
    logic signed [SCORE_W-1:0]     bnd;      // (i-1)*GAP for the row being fed
    logic [SEQ_LEN*BASE_W-1:0]     ref_q;
    logic [SEQ_LEN*BASE_W-1:0]     qry_sh;

    // Chain taps, index 0 is the feed and g+1 the output of cell g
    logic [SEQ_LEN:0]              v;
    logic [SEQ_LEN:0][BASE_W-1:0]  q;
    logic [SEQ_LEN:0][IDX_W-1:0]   r;
    logic signed [SCORE_W-1:0]     s [SEQ_LEN+1];
    logic signed [SCORE_W-1:0]     d [SEQ_LEN+1];

    assign accept = start && !busy;
    assign busy   = busy_q && !done;  // Low in the done cycle

    // ##############################
    // Start and row feed

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q   <= 1'b0;
            feeding  <= 1'b0;
            feed_row <= '0;
            bnd      <= '0;
        end else begin
            if (accept) begin
                busy_q <= 1'b1;
            end else if (done) begin
                busy_q <= 1'b0;
            end
            if (accept) begin
                feeding  <= 1'b1;
                feed_row <= IDX_W'(1);
                bnd      <= '0;
            end else if (feeding) begin
                feeding  <= (feed_row != IDX_W'(SEQ_LEN));
                feed_row <= feed_row + 1'b1;
                bnd      <= bnd + GAP_SCORE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ref_q  <= ref_seq;
            qry_sh <= qry_seq;
        end else if (feeding) begin
            qry_sh <= qry_sh >> BASE_W;   // Next query base to bit 0
        end
    end

    assign v[0] = feeding;
    assign q[0] = qry_sh[BASE_W-1:0];
    assign r[0] = feed_row;
    assign d[0] = bnd;
    assign s[0] = bnd + GAP_SCORE;        // H[i][0]

    // ##############################
    // Systolic row

    for (genvar g = 0; g < SEQ_LEN; g++) begin : g_col
        nw_cell i_cell (
            .clk       (clk),
            .rst_n     (rst_n),
            .in_valid  (v[g]),
            .in_qry    (q[g]),
            .ref_base  (ref_q[g*BASE_W +: BASE_W]),
            .diag      (d[g]),
            .left      (s[g]),
            .up_init   (SCORE_W'((g + 1) * GAP_SCORE)),
            .out_valid (v[g+1]),
            .out_qry   (q[g+1]),
            .out_score (s[g+1]),
            .out_diag  (d[g+1]),
            .out_dir   (wr_dir[g])
        );

        always_ff @(posedge clk) begin
            if (v[g]) begin
                r[g+1] <= r[g];           // Row index rides with the valid
            end
        end

        assign wr_en[g]  = v[g+1];
        assign wr_row[g] = r[g+1];
    end

    assign fill_done   = v[SEQ_LEN] && (r[SEQ_LEN] == IDX_W'(SEQ_LEN));
    assign final_score = s[SEQ_LEN];

endmodule

`default_nettype wire

//--- hw/nw_cell.sv
`timescale 1ns/1ps
`default_nettype none

module nw_cell
    import nw_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_valid,
    input  logic [BASE_W-1:0]         in_qry,
    input  logic [BASE_W-1:0]         ref_base,
    input  logic signed [SCORE_W-1:0] diag,
    input  logic signed [SCORE_W-1:0] left,
    input  logic signed [SCORE_W-1:0] up_init,
    output logic                      out_valid,
    output logic [BASE_W-1:0]         out_qry,
    output logic signed [SCORE_W-1:0] out_score,
    output logic signed [SCORE_W-1:0] out_diag,
    output logic [DIR_W-1:0]          out_dir
);

    logic signed [SCORE_W-1:0] up_cur;
    logic signed [SCORE_W-1:0] diag_c;
    logic signed [SCORE_W-1:0] up_c;
    logic signed [SCORE_W-1:0] left_c;
    logic signed [SCORE_W-1:0] win_c;
    logic signed [SCORE_W-1:0] win_p;
    logic signed [SCORE_W-1:0] best_c;
    logic [DIR_W-1:0]          win_dir;
    logic [DIR_W-1:0]          best_dir;

    // out_score doubles as the previous-row score of this column
    assign up_cur = (in_valid && !out_valid) ? up_init : out_score;  // First row of a burst

    assign diag_c = (in_qry == ref_base) ? diag + MATCH_SCORE : diag + MISMATCH_SCORE;
    assign up_c   = up_cur + GAP_SCORE;
    assign left_c = left + GAP_SCORE;

    always_comb begin
        // Diag against up, diag wins a full tie
        if (diag_c > up_c || (diag_c == up_c && diag >= up_cur)) begin
            win_c   = diag_c;
            win_p   = diag;
            win_dir = DIR_DIAG;
        end else begin
            win_c   = up_c;
            win_p   = up_cur;
            win_dir = DIR_UP;
        end
        if (left_c > win_c || (left_c == win_c && left > win_p)) begin
            best_c   = left_c;
            best_dir = DIR_LEFT;
        end else begin
            best_c   = win_c;
            best_dir = win_dir;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_score <= best_c;
            out_dir   <= best_dir;
            out_qry   <= in_qry;
            out_diag  <= up_cur;   // H[i-1][j] for the next column
        end
    end

endmodule

`default_nettype wire

//--- hw/nw_pkg.sv
`default_nettype none

package nw_pkg;

    // ##############################
    // Sizes

    localparam int SEQ_LEN = 8;
    localparam int BASE_W  = 2;
    localparam int SCORE_W = 9;    // Signed, worst case -2*SEQ_LEN
    localparam int IDX_W   = 4;    // Holds 0 .. SEQ_LEN

    // ##############################
    // Scoring

    localparam logic signed [SCORE_W-1:0] MATCH_SCORE    = SCORE_W'(1);
    localparam logic signed [SCORE_W-1:0] MISMATCH_SCORE = SCORE_W'(-1);
    localparam logic signed [SCORE_W-1:0] GAP_SCORE      = SCORE_W'(-1);

    // ##############################
    // Traceback symbols, one-hot

    localparam int DIR_W = 3;

    localparam logic [DIR_W-1:0] DIR_DIAG = 3'b001;
    localparam logic [DIR_W-1:0] DIR_UP   = 3'b010;
    localparam logic [DIR_W-1:0] DIR_LEFT = 3'b100;

endpackage

`default_nettype wire

//--- hw/nw_top.sv
`timescale 1ns/1ps
`default_nettype none

module nw_top
    import nw_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  logic [SEQ_LEN*BASE_W-1:0] ref_seq,
    input  logic [SEQ_LEN*BASE_W-1:0] qry_seq,
    output logic                      busy,
    output logic                      path_valid,
    output logic [DIR_W-1:0]          path_dir,
    output logic                      done,
    output logic signed [SCORE_W-1:0] score
);

    logic [SEQ_LEN-1:0]            wr_en;
    logic [SEQ_LEN-1:0][IDX_W-1:0] wr_row;
    logic [SEQ_LEN-1:0][DIR_W-1:0] wr_dir;
    logic signed [SCORE_W-1:0]     final_score;
    logic                          fill_done;
    logic [IDX_W-1:0]              rd_row;
    logic [IDX_W-1:0]              rd_col;
    logic [DIR_W-1:0]              rd_dir;

    nw_array i_array (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .ref_seq     (ref_seq),
        .qry_seq     (qry_seq),
        .done        (done),
        .busy        (busy),
        .wr_en       (wr_en),
        .wr_row      (wr_row),
        .wr_dir      (wr_dir),
        .final_score (final_score),
        .fill_done   (fill_done)
    );

    dir_store i_store (
        .clk    (clk),
        .wr_en  (wr_en),
        .wr_row (wr_row),
        .wr_dir (wr_dir),
        .rd_row (rd_row),
        .rd_col (rd_col),
        .rd_dir (rd_dir)
    );

    traceback i_traceback (
        .clk         (clk),
        .rst_n       (rst_n),
        .fill_done   (fill_done),
        .final_score (final_score),
        .rd_row      (rd_row),
        .rd_col      (rd_col),
        .rd_dir      (rd_dir),
        .path_valid  (path_valid),
        .path_dir    (path_dir),
        .done        (done),
        .score       (score)
    );

endmodule

`default_nettype wire

//--- hw/traceback.sv
`timescale 1ns/1ps
`default_nettype none

module traceback
    import nw_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      fill_done,
    input  logic signed [SCORE_W-1:0] final_score,
    output logic [IDX_W-1:0]          rd_row,
    output logic [IDX_W-1:0]          rd_col,
    input  logic [DIR_W-1:0]          rd_dir,
    output logic                      path_valid,
    output logic [DIR_W-1:0]          path_dir,
    output logic                      done,
    output logic signed [SCORE_W-1:0] score
);

    typedef enum logic {
        S_IDLE,
        S_WALK
    } state_t;

    state_t                    state;
    logic [IDX_W-1:0]          row;
    logic [IDX_W-1:0]          col;
    logic [DIR_W-1:0]          move;
    logic                      at_origin;
    logic signed [SCORE_W-1:0] score_q;

    assign rd_row    = row;
    assign rd_col    = col;
    assign score     = score_q;
    assign at_origin = (row == '0) && (col == '0);

    always_comb begin
        if (row == '0) begin
            move = DIR_LEFT;                // Top edge
        end else if (col == '0) begin
            move = DIR_UP;                  // Left edge
        end else begin
            case (rd_dir)
                DIR_UP:   move = DIR_UP;
                DIR_LEFT: move = DIR_LEFT;
                default:  move = DIR_DIAG;
            endcase
        end
    end

    // ##############################
    // Walk FSM

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= S_IDLE;
            row        <= '0;
            col        <= '0;
            path_valid <= 1'b0;
            done       <= 1'b0;
        end else begin
            path_valid <= 1'b0;
            done       <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (fill_done) begin
                        state <= S_WALK;
                        row   <= IDX_W'(SEQ_LEN);   // Bottom-right corner
                        col   <= IDX_W'(SEQ_LEN);
                    end
                end
                S_WALK: begin
                    if (at_origin) begin
                        done  <= 1'b1;
                        state <= S_IDLE;
                    end else begin
                        path_valid <= 1'b1;
                        if (move != DIR_LEFT) begin
                            row <= row - 1'b1;
                        end
                        if (move != DIR_UP) begin
                            col <= col - 1'b1;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && fill_done) begin
            score_q <= final_score;
        end
        if (state == S_WALK && !at_origin) begin
            path_dir <= move;
        end
    end

endmodule

`default_nettype wire

//--- list.f
hw/nw_pkg.sv
hw/nw_cell.sv
hw/nw_array.sv
hw/dir_store.sv
hw/traceback.sv
hw/nw_top.sv
tb/tb_clk.sv
tb/nw_tb.sv

//--- tb/nw_tb.sv
`timescale 1ns/1ps
`default_nettype none

module nw_tb
    import nw_pkg::*;
();

    logic                         clk;
    logic                         rst_n;
    logic                         start;
    logic [SEQ_LEN*BASE_W-1:0]    ref_seq;
    logic [SEQ_LEN*BASE_W-1:0]    qry_seq;
    logic                         busy;
    logic                         path_valid;
    logic [DIR_W-1:0]             path_dir;
    logic                         done;
    logic signed [SCORE_W-1:0]    score;

    logic [31:0]                  rng;
    logic [2*SEQ_LEN*DIR_W-1:0]   got_moves;
    int                           got_count;
    logic signed [SCORE_W-1:0]    got_score;

    tb_clk i_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    nw_top i_nw_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .ref_seq    (ref_seq),
        .qry_seq    (qry_seq),
        .busy       (busy),
        .path_valid (path_valid),
        .path_dir   (path_dir),
        .done       (done),
        .score      (score)
    );

    task automatic abort_run();
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic rand_seq(output logic [SEQ_LEN*BASE_W-1:0] s);
        for (int k = 0; k < SEQ_LEN; k++) begin
            rng = lcg_next(rng);
            s[k*BASE_W +: BASE_W] = rng[31:30];    // Upper bits of the LCG
        end
    endtask

    // ##############################
    // Reference alignment model

    function automatic void align_model(
        input  logic [SEQ_LEN*BASE_W-1:0]  rs,
        input  logic [SEQ_LEN*BASE_W-1:0]  qs,
        output int                         sc,
        output logic [2*SEQ_LEN*DIR_W-1:0] mv,
        output int                         n
    );
        int               h [0:SEQ_LEN][0:SEQ_LEN];
        logic [DIR_W-1:0] dr [0:SEQ_LEN][0:SEQ_LEN];
        int               cand [3];
        int               pred [3];
        int               best;
        int               i;
        int               j;
        logic [DIR_W-1:0] step;
        for (i = 0; i <= SEQ_LEN; i++) begin
            h[i][0] = i * int'(GAP_SCORE);
            h[0][i] = i * int'(GAP_SCORE);
        end
        for (i = 1; i <= SEQ_LEN; i++) begin
            for (j = 1; j <= SEQ_LEN; j++) begin
                pred[0] = h[i-1][j-1];
                pred[1] = h[i-1][j];
                pred[2] = h[i][j-1];
                if (qs[(i-1)*BASE_W +: BASE_W] == rs[(j-1)*BASE_W +: BASE_W])
                    cand[0] = pred[0] + int'(MATCH_SCORE);
                else
                    cand[0] = pred[0] + int'(MISMATCH_SCORE);
                cand[1] = pred[1] + int'(GAP_SCORE);
                cand[2] = pred[2] + int'(GAP_SCORE);
                best = 0;                                   // Order diag, up, left
                for (int k = 1; k < 3; k++) begin
                    if (cand[k] > cand[best] ||
                        (cand[k] == cand[best] && pred[k] > pred[best]))
                        best = k;
                end
                h[i][j]  = cand[best];
                dr[i][j] = (best == 0) ? DIR_DIAG : (best == 1) ? DIR_UP : DIR_LEFT;
            end
        end
        sc = h[SEQ_LEN][SEQ_LEN];
        mv = '0;
        n  = 0;
        i  = SEQ_LEN;
        j  = SEQ_LEN;
        while (i > 0 || j > 0) begin
            if (i == 0)
                step = DIR_LEFT;
            else if (j == 0)
                step = DIR_UP;
            else
                step = dr[i][j];
            mv[n*DIR_W +: DIR_W] = step;
            n++;
            if (step != DIR_LEFT) i--;
            if (step != DIR_UP) j--;
        end
    endfunction

    // ##############################
    // One alignment, checked move by move

    task automatic run_align(
        input logic [SEQ_LEN*BASE_W-1:0] rs,
        input logic [SEQ_LEN*BASE_W-1:0] qs,
        input logic                      poke_busy
    );
        int                         exp_sc;
        logic [2*SEQ_LEN*DIR_W-1:0] exp_mv;
        int                         exp_n;
        int                         row;
        int                         col;
        logic                       finished;
        align_model(rs, qs, exp_sc, exp_mv, exp_n);
        got_moves = '0;
        got_count = 0;
        row       = SEQ_LEN;
        col       = SEQ_LEN;
        finished  = 1'b0;
        @(posedge clk);
        start   <= 1'b1;
        ref_seq <= rs;
        qry_seq <= qs;
        @(posedge clk);
        start <= 1'b0;
        for (int cyc = 0; cyc < 200 && !finished; cyc++) begin
            @(negedge clk);
            assert (busy === !done) else begin
                $display("Error: busy is %h while done is %h", busy, done);
                abort_run();
            end
            if (path_valid) begin
                assert (got_count < exp_n) else begin
                    $display("More path moves than the %0d expected", exp_n);
                    abort_run();
                end
                assert (path_dir === exp_mv[got_count*DIR_W +: DIR_W]) else begin
                    $display("Error: path_dir move %0d got %h expected %h", got_count,
                             path_dir, exp_mv[got_count*DIR_W +: DIR_W]);
                    abort_run();
                end
                got_moves[got_count*DIR_W +: DIR_W] = path_dir;
                got_count++;
                if (path_dir != DIR_LEFT) row--;
                if (path_dir != DIR_UP) col--;
                assert (row >= 0 && col >= 0) else begin
                    $display("Path walked past the origin");
                    abort_run();
                end
            end
            if (done) begin
                finished  = 1'b1;
                got_score = score;
                assert (score === SCORE_W'(exp_sc)) else begin
                    $display("Error: score got %h expected %h", score, SCORE_W'(exp_sc));
                    abort_run();
                end
                assert (got_count == exp_n) else begin
                    $display("Error: path_valid count got %h expected %h", got_count, exp_n);
                    abort_run();
                end
                assert (row == 0 && col == 0) else begin
                    $display("Path ended at row %0d column %0d, not at the origin", row, col);
                    abort_run();
                end
            end
            @(posedge clk);
            if (poke_busy && cyc == 4) begin
                start   <= 1'b1;        // Ignored while the fill runs
                ref_seq <= ~rs;
                qry_seq <= qs;
            end else begin
                start <= 1'b0;
            end
        end
        assert (finished) else begin
            $display("Timed out waiting for done");
            abort_run();
        end
    endtask

    task automatic check_all_diag(input logic signed [SCORE_W-1:0] exp_score);
        assert (got_score === exp_score) else begin
            $display("Error: score got %h expected %h", got_score, exp_score);
            abort_run();
        end
        assert (got_count == SEQ_LEN) else begin
            $display("Error: path_valid count got %h expected %h", got_count, SEQ_LEN);
            abort_run();
        end
        for (int k = 0; k < SEQ_LEN; k++) begin
            assert (got_moves[k*DIR_W +: DIR_W] === DIR_DIAG) else begin
                $display("Error: path_dir move %0d got %h expected %h", k,
                         got_moves[k*DIR_W +: DIR_W], DIR_DIAG);
                abort_run();
            end
        end
    endtask

    initial begin
        logic [SEQ_LEN*BASE_W-1:0] rs;
        logic [SEQ_LEN*BASE_W-1:0] qs;
        start   = 1'b0;
        ref_seq = '0;
        qry_seq = '0;
        rng     = 32'h7aee_2c3c;

        for (int k = 0; k < 50 && rst_n !== 1'b1; k++) @(negedge clk);
        assert (rst_n === 1'b1) else begin
            $display("Timed out waiting for reset release");
            abort_run();
        end

        for (int k = 0; k < 5; k++) begin
            @(negedge clk);
            assert (!busy && !path_valid && !done) else begin
                $display("Error: after reset busy %h path_valid %h done %h",
                         busy, path_valid, done);
                abort_run();
            end
        end

        rand_seq(rs);
        run_align(rs, rs, 1'b0);
        check_all_diag(SCORE_W'(SEQ_LEN * int'(MATCH_SCORE)));

        for (int t = 0; t < 20; t++) begin
            rand_seq(rs);
            rand_seq(qs);
            run_align(rs, qs, 1'b0);
        end

        // Query base k is reference base k-1
        rand_seq(rs);
        qs = {rs[SEQ_LEN*BASE_W-BASE_W-1:0], rs[SEQ_LEN*BASE_W-1 -: BASE_W]};
        run_align(rs, qs, 1'b0);

        // Mismatch and gap cost the same, so diag takes every tie
        rand_seq(rs);
        rs = rs & {SEQ_LEN{2'b01}};     // Reference bases 0 and 1 only
        qs = rs | {SEQ_LEN{2'b10}};     // Query bases 2 and 3 only
        run_align(rs, qs, 1'b0);
        check_all_diag(SCORE_W'(SEQ_LEN * int'(MISMATCH_SCORE)));

        rand_seq(rs);
        rand_seq(qs);
        run_align(rs, qs, 1'b1);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/tb_clk.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;    // 20 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire
